// File: include/regbridge_macros.svh
`ifndef REGBRIDGE_MACROS_SVH
`define REGBRIDGE_MACROS_SVH

// log2 of the depth of both clock crossing FIFOs
`define REGBRIDGE_FIFO_ABITS 3

// register index width, 16 registers
`define REGBRIDGE_ADDR_W 4

// register and bus data width
`define REGBRIDGE_DATA_W 32

// read tag width, wraps every 16 reads
`define REGBRIDGE_TAG_W 4

`endif

// File: src.f
+incdir+include
src/bridge_msg_pkg.sv
src/regbank_pkg.sv
src/cdc_afifo.sv
src/bus_cmd_ingress.sv
src/reg_bank_exec.sv
src/rsp_egress.sv
src/regbridge_top.sv
tb/tb_regbridge.sv

// File: src/bridge_msg_pkg.sv
`default_nettype none

`include "regbridge_macros.svh"

// messages that cross between the two clock domains
package bridge_msg_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } bridge_op_e;

    // command, write domain to read domain
    typedef struct packed {
        bridge_op_e                  op;
        logic [`REGBRIDGE_ADDR_W-1:0] addr;
        logic [`REGBRIDGE_DATA_W-1:0] wdata;  // don't care on reads
        logic [`REGBRIDGE_TAG_W-1:0]  tag;    // only meaningful on reads
    } bridge_cmd_t;

    // read response, back to the write domain
    typedef struct packed {
        logic [`REGBRIDGE_DATA_W-1:0] rdata;
        logic [`REGBRIDGE_TAG_W-1:0]  tag;
    } bridge_rsp_t;

endpackage : bridge_msg_pkg

`default_nettype wire

// File: src/bus_cmd_ingress.sv
`default_nettype none

`include "regbridge_macros.svh"

// request side: builds commands, hands out read tags, counts drops
module bus_cmd_ingress
    import bridge_msg_pkg::*;
    import regbank_pkg::*;
(
    input  wire logic      i_wclk,
    input  wire logic      i_wrstn,
    // requester
    input  wire logic      i_req,
    input  wire logic      i_we,
    input  wire reg_idx_t  i_addr,
    input  wire reg_word_t i_wdata,
    // command FIFO write side
    input  wire logic      i_fifo_full,
    output logic           o_fifo_wr,
    output bridge_cmd_t    o_fifo_cmd,
    // status
    output logic           o_busy,
    output logic [15:0]    o_drop_cnt
);

    logic [`REGBRIDGE_TAG_W-1:0] next_tag;
    logic [15:0]                 drop_cnt;
    logic                        accept;
    logic                        drop;

    assign accept = i_req & ~i_fifo_full;
    assign drop   = i_req & i_fifo_full;

    always_comb begin
        o_fifo_cmd.op    = i_we ? OP_WRITE : OP_READ;
        o_fifo_cmd.addr  = i_addr;
        o_fifo_cmd.wdata = i_we ? i_wdata : '0;
        o_fifo_cmd.tag   = i_we ? '0 : next_tag;
    end

    // pushed in the cycle of the request
    assign o_fifo_wr = accept;

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            next_tag <= '0;
            drop_cnt <= '0;
        end else begin
            if (accept && !i_we) begin
                next_tag <= next_tag + 1'b1;  // wraps
            end
            if (drop && (drop_cnt != 16'hffff)) begin
                drop_cnt <= drop_cnt + 16'd1;
            end
        end
    end

    assign o_busy     = i_fifo_full;
    assign o_drop_cnt = drop_cnt;

    // a changed count means exactly one request was refused one edge earlier
    a_drop_only_when_full : assert property (
        @(posedge i_wclk) disable iff (!i_wrstn)
        (o_drop_cnt != $past(o_drop_cnt)) |->
            ($past(i_req && i_fifo_full) && (o_drop_cnt == $past(o_drop_cnt) + 16'd1))
    );

endmodule : bus_cmd_ingress

`default_nettype wire

// File: src/cdc_afifo.sv
`default_nettype none

// dual clock FIFO, gray coded pointers with two flop synchronizers
module cdc_afifo #(
    parameter int  abits     = 3,            // log2 of depth, at least 2
    parameter type t_payload = logic [31:0]
) (
    // write side
    input  wire logic i_wclk,
    input  wire logic i_wrstn,
    input  wire logic i_wr,
    input  wire t_payload i_wdata,
    output logic      o_wfull,
    // read side
    input  wire logic i_rclk,
    input  wire logic i_rrstn,
    input  wire logic i_rd,
    output t_payload  o_rdata,
    output logic      o_rempty
);

    localparam int depth = 1 << abits;

    t_payload mem [depth];

    // write domain
    logic [abits:0] wbin;
    logic [abits:0] wgray;
    logic [abits:0] wq1_rgray;
    logic [abits:0] wq2_rgray;
    logic [abits:0] wbin_next;
    logic [abits:0] wgray_next;
    logic           wfull;
    logic           wpush;

    // read domain
    logic [abits:0] rbin;
    logic [abits:0] rgray;
    logic [abits:0] rq1_wgray;
    logic [abits:0] rq2_wgray;
    logic [abits:0] rbin_next;
    logic [abits:0] rgray_next;
    logic           rempty;
    logic           rpop;

    assign wpush      = i_wr & ~wfull;  // strobe ignored while full
    assign wbin_next  = wbin + {{abits{1'b0}}, wpush};
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin      <= '0;
            wgray     <= '0;
            wq1_rgray <= '0;
            wq2_rgray <= '0;
            wfull     <= 1'b0;
        end else begin
            wbin      <= wbin_next;
            wgray     <= wgray_next;
            wq1_rgray <= rgray;  // crossing from rclk
            wq2_rgray <= wq1_rgray;
            // full when writer is one lap ahead: top two gray bits inverted
            wfull     <= (wgray_next == {~wq2_rgray[abits:abits-1], wq2_rgray[abits-2:0]});
        end
    end

    always_ff @(posedge i_wclk) begin
        if (wpush) begin
            mem[wbin[abits-1:0]] <= i_wdata;
        end
    end

    assign rpop       = i_rd & ~rempty;
    assign rbin_next  = rbin + {{abits{1'b0}}, rpop};
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin      <= '0;
            rgray     <= '0;
            rq1_wgray <= '0;
            rq2_wgray <= '0;
            rempty    <= 1'b1;
        end else begin
            rbin      <= rbin_next;
            rgray     <= rgray_next;
            rq1_wgray <= wgray;  // crossing from wclk
            rq2_wgray <= rq1_wgray;
            rempty    <= (rgray_next == rq2_wgray);
        end
    end

    // head entry, valid while not empty
    assign o_rdata  = mem[rbin[abits-1:0]];
    assign o_wfull  = wfull;
    assign o_rempty = rempty;

    // the bridge blocks never lean on the FIFO dropping a strobe
    a_no_push_full : assert property (
        @(posedge i_wclk) disable iff (!i_wrstn) i_wr |-> !o_wfull
    );

    a_no_pop_empty : assert property (
        @(posedge i_rclk) disable iff (!i_rrstn) i_rd |-> !o_rempty
    );

endmodule : cdc_afifo

`default_nettype wire

// File: src/reg_bank_exec.sv
`default_nettype none

// read clock side: runs the head command against the register bank
module reg_bank_exec
    import bridge_msg_pkg::*;
    import regbank_pkg::*;
(
    input  wire logic        i_rclk,
    input  wire logic        i_rrstn,
    // command FIFO read side
    input  wire logic        i_cmd_empty,
    input  wire bridge_cmd_t i_cmd,
    output logic             o_cmd_rd,
    // response FIFO write side
    input  wire logic        i_rsp_full,
    output logic             o_rsp_wr,
    output bridge_rsp_t      o_rsp
);

    reg_word_t regs [REG_COUNT];

    reg_idx_t idx;
    logic     head_wr;
    logic     head_rd;
    logic     rd_stall;

    assign idx = reg_idx_t'(i_cmd.addr);

    // decode of the head entry, only when there is one
    assign head_wr = ~i_cmd_empty & (i_cmd.op == OP_WRITE);
    assign head_rd = ~i_cmd_empty & (i_cmd.op == OP_READ);

    // read waits at the head until the response has room
    assign rd_stall = head_rd & i_rsp_full;

    assign o_cmd_rd = head_wr | (head_rd & ~rd_stall);
    assign o_rsp_wr = head_rd & ~rd_stall;

    // response taken straight from the bank, same cycle as the pop
    assign o_rsp.rdata = regs[idx];
    assign o_rsp.tag   = i_cmd.tag;

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (head_wr) begin
            regs[idx] <= i_cmd.wdata;
        end
    end

    // while the response FIFO is full nothing is pushed and the
    // stalled read is still the same head entry on the next edge
    a_rsp_backpressure : assert property (
        @(posedge i_rclk) disable iff (!i_rrstn)
        (head_rd && i_rsp_full) |->
            !o_rsp_wr ##1 (!i_cmd_empty && (i_cmd == $past(i_cmd)))
    );

endmodule : reg_bank_exec

`default_nettype wire

// File: src/regbank_pkg.sv
`default_nettype none

`include "regbridge_macros.svh"

package regbank_pkg;

    // one register per address value
    localparam int REG_COUNT = 1 << `REGBRIDGE_ADDR_W;

    typedef logic [`REGBRIDGE_ADDR_W-1:0] reg_idx_t;
    typedef logic [`REGBRIDGE_DATA_W-1:0] reg_word_t;

endpackage : regbank_pkg

`default_nettype wire

// File: src/regbridge_top.sv
`default_nettype none

`include "regbridge_macros.svh"

module regbridge_top
    import bridge_msg_pkg::*;
    import regbank_pkg::*;
(
    input  wire logic                    i_wclk,
    input  wire logic                    i_wrstn,
    input  wire logic                    i_rclk,
    input  wire logic                    i_rrstn,
    // requester, wclk domain
    input  wire logic                    i_req,
    input  wire logic                    i_we,
    input  wire reg_idx_t                i_addr,
    input  wire reg_word_t               i_wdata,
    output logic                         o_busy,
    output logic [15:0]                  o_drop_cnt,
    // read return, wclk domain
    output logic                         o_rvalid,
    output reg_word_t                    o_rdata,
    output logic [`REGBRIDGE_TAG_W-1:0]  o_rtag,
    output logic                         o_seq_err
);

    // command path
    logic        cmd_wr;
    bridge_cmd_t cmd_in;
    logic        cmd_full;
    logic        cmd_rd;
    bridge_cmd_t cmd_head;
    logic        cmd_empty;

    // response path
    logic        rsp_wr;
    bridge_rsp_t rsp_in;
    logic        rsp_full;
    logic        rsp_rd;
    bridge_rsp_t rsp_head;
    logic        rsp_empty;

    bus_cmd_ingress u_ingress (
        .i_wclk      (i_wclk),
        .i_wrstn     (i_wrstn),
        .i_req       (i_req),
        .i_we        (i_we),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_fifo_full (cmd_full),
        .o_fifo_wr   (cmd_wr),
        .o_fifo_cmd  (cmd_in),
        .o_busy      (o_busy),
        .o_drop_cnt  (o_drop_cnt)
    );

    cdc_afifo #(
        .abits     (`REGBRIDGE_FIFO_ABITS),
        .t_payload (bridge_cmd_t)
    ) u_cmd_fifo (
        .i_wclk   (i_wclk),
        .i_wrstn  (i_wrstn),
        .i_wr     (cmd_wr),
        .i_wdata  (cmd_in),
        .o_wfull  (cmd_full),
        .i_rclk   (i_rclk),
        .i_rrstn  (i_rrstn),
        .i_rd     (cmd_rd),
        .o_rdata  (cmd_head),
        .o_rempty (cmd_empty)
    );

    reg_bank_exec u_exec (
        .i_rclk      (i_rclk),
        .i_rrstn     (i_rrstn),
        .i_cmd_empty (cmd_empty),
        .i_cmd       (cmd_head),
        .o_cmd_rd    (cmd_rd),
        .i_rsp_full  (rsp_full),
        .o_rsp_wr    (rsp_wr),
        .o_rsp       (rsp_in)
    );

    // return path runs rclk to wclk
    cdc_afifo #(
        .abits     (`REGBRIDGE_FIFO_ABITS),
        .t_payload (bridge_rsp_t)
    ) u_rsp_fifo (
        .i_wclk   (i_rclk),
        .i_wrstn  (i_rrstn),
        .i_wr     (rsp_wr),
        .i_wdata  (rsp_in),
        .o_wfull  (rsp_full),
        .i_rclk   (i_wclk),
        .i_rrstn  (i_wrstn),
        .i_rd     (rsp_rd),
        .o_rdata  (rsp_head),
        .o_rempty (rsp_empty)
    );

    rsp_egress u_egress (
        .i_wclk      (i_wclk),
        .i_wrstn     (i_wrstn),
        .i_rsp_empty (rsp_empty),
        .i_rsp       (rsp_head),
        .o_rsp_rd    (rsp_rd),
        .o_rvalid    (o_rvalid),
        .o_rdata     (o_rdata),
        .o_rtag      (o_rtag),
        .o_seq_err   (o_seq_err)
    );

endmodule : regbridge_top

`default_nettype wire

// File: src/rsp_egress.sv
`default_nettype none

`include "regbridge_macros.svh"

// response side: pops read data, registers outputs, checks tag order
module rsp_egress
    import bridge_msg_pkg::*;
    import regbank_pkg::*;
(
    input  wire logic                    i_wclk,
    input  wire logic                    i_wrstn,
    // response FIFO read side
    input  wire logic                    i_rsp_empty,
    input  wire bridge_rsp_t             i_rsp,
    output logic                         o_rsp_rd,
    // requester
    output logic                         o_rvalid,
    output reg_word_t                    o_rdata,
    output logic [`REGBRIDGE_TAG_W-1:0]  o_rtag,
    output logic                         o_seq_err
);

    logic [`REGBRIDGE_TAG_W-1:0] exp_tag;
    logic                        pop;

    assign pop      = ~i_rsp_empty;  // always ready
    assign o_rsp_rd = pop;

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            o_rvalid  <= 1'b0;
            exp_tag   <= '0;
            o_seq_err <= 1'b0;
        end else begin
            o_rvalid <= pop;
            if (pop) begin
                exp_tag <= exp_tag + 1'b1;
                if (i_rsp.tag != exp_tag) begin
                    o_seq_err <= 1'b1;  // sticky until reset
                end
            end
        end
    end

    // payload, qualified by o_rvalid
    always_ff @(posedge i_wclk) begin
        if (pop) begin
            o_rdata <= i_rsp.rdata;
            o_rtag  <= i_rsp.tag;
        end
    end

endmodule : rsp_egress

`default_nettype wire

// File: tb/tb_regbridge.sv
`default_nettype none

`include "regbridge_macros.svh"

module tb_regbridge
    import bridge_msg_pkg::*;
    import regbank_pkg::*;
;

    typedef logic [`REGBRIDGE_TAG_W-1:0] tag_t;

    // requests over all tests and the worst round trip in wclk cycles
    localparam int total_reqs = 16 + 16 + 48 + 200 + 24;
    localparam int round_trip = 40;
    localparam int cycle_limit = total_reqs * round_trip + 500;

    logic        i_wclk;
    logic        i_wrstn;
    logic        i_rclk;
    logic        i_rrstn;
    logic        i_req;
    logic        i_we;
    reg_idx_t    i_addr;
    reg_word_t   i_wdata;
    logic        o_busy;
    logic [15:0] o_drop_cnt;
    logic        o_rvalid;
    reg_word_t   o_rdata;
    tag_t        o_rtag;
    logic        o_seq_err;

    // reference model
    reg_word_t model [REG_COUNT];
    reg_word_t exp_data_q [$];
    tag_t      exp_tag_q [$];
    tag_t      exp_tag;
    int        exp_drops;
    int        busy_drives;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;

    regbridge_top u_regbridge_top (
        .i_wclk     (i_wclk),
        .i_wrstn    (i_wrstn),
        .i_rclk     (i_rclk),
        .i_rrstn    (i_rrstn),
        .i_req      (i_req),
        .i_we       (i_we),
        .i_addr     (i_addr),
        .i_wdata    (i_wdata),
        .o_busy     (o_busy),
        .o_drop_cnt (o_drop_cnt),
        .o_rvalid   (o_rvalid),
        .o_rdata    (o_rdata),
        .o_rtag     (o_rtag),
        .o_seq_err  (o_seq_err)
    );

    initial begin
        i_wclk = 1'b0;
        forever #10 i_wclk = ~i_wclk;
    end

    // unrelated read clock
    initial begin
        i_rclk = 1'b0;
        forever #17 i_rclk = ~i_rclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // each o_rvalid pulse retires the oldest outstanding read
    always @(negedge i_wclk) begin
        if (o_rvalid === 1'b1) begin
            if (exp_tag_q.size() == 0) begin
                errors++;
                $display("t=%0t read response arrived with no read outstanding", $time);
            end else begin
                check_word("o_rdata", o_rdata, exp_data_q.pop_front());
                check_tag("o_rtag", o_rtag, exp_tag_q.pop_front());
            end
        end
    end

    always @(posedge i_wclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d wclk cycles, %0d reads still outstanding",
                     cycles, exp_tag_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // drives one request and updates the model from the busy level
    task automatic drive_req(input logic we, input reg_idx_t addr, input reg_word_t data,
                             input logic wait_free);
        @(negedge i_wclk);
        if (wait_free) begin
            while (o_busy) begin
                i_req = 1'b0;
                @(negedge i_wclk);
            end
        end
        i_req   = 1'b1;
        i_we    = we;
        i_addr  = addr;
        i_wdata = data;
        if (o_busy) begin
            exp_drops++;  // refused at the coming edge
            busy_drives++;
        end else if (we) begin
            model[addr] = data;
        end else begin
            exp_data_q.push_back(model[addr]);
            exp_tag_q.push_back(exp_tag);
            exp_tag++;
        end
    endtask

    task automatic release_req();
        @(negedge i_wclk);
        i_req = 1'b0;
        i_we  = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_tag_q.size() != 0) begin
            @(negedge i_wclk);
        end
    endtask

    task automatic finish_test(input string name, input int err_base);
        check_flag("o_seq_err", o_seq_err, 1'b0);
        $display("test %s done, %0d errors", name, errors - err_base);
    endtask

    task automatic test_reset_values();
        int base;
        base = errors;
        for (int i = 0; i < REG_COUNT; i++) begin
            drive_req(1'b0, reg_idx_t'(i), '0, 1'b1);
        end
        release_req();
        wait_responses();
        finish_test("reset_values", base);
    endtask

    task automatic test_single_write_read();
        int        base;
        reg_idx_t  a;
        reg_word_t d;
        base = errors;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            a   = rng[7:4];
            rng = xorshift32(rng);
            d   = rng;
            drive_req(1'b1, a, d, 1'b1);
            release_req();
            drive_req(1'b0, a, '0, 1'b1);  // waits for o_busy low
            release_req();
            wait_responses();
        end
        finish_test("single_write_read", base);
    endtask

    task automatic test_burst_overflow();
        int base;
        int busy_base;
        base      = errors;
        busy_base = busy_drives;
        for (int i = 0; i < 32; i++) begin
            rng = xorshift32(rng);
            drive_req(1'b1, reg_idx_t'(i), rng, 1'b0);
        end
        release_req();
        if (busy_drives == busy_base) begin
            errors++;
            $display("t=%0t burst of writes never saw o_busy, nothing was dropped", $time);
        end
        // readback shows only the writes that got in
        for (int i = 0; i < REG_COUNT; i++) begin
            drive_req(1'b0, reg_idx_t'(i), '0, 1'b1);
        end
        release_req();
        wait_responses();
        check_count("o_drop_cnt", o_drop_cnt, exp_drops[15:0]);
        finish_test("burst_overflow", base);
    endtask

    task automatic test_random_mix();
        int        base;
        logic      we;
        reg_idx_t  a;
        reg_word_t d;
        base = errors;
        for (int i = 0; i < 200; i++) begin
            rng = xorshift32(rng);
            we  = rng[0];
            a   = rng[7:4];
            rng = xorshift32(rng);
            d   = rng;
            drive_req(we, a, d, 1'b1);
        end
        release_req();
        wait_responses();
        finish_test("random_mix", base);
    endtask

    task automatic test_rsp_backpressure();
        int base;
        base = errors;
        for (int i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            drive_req(1'b0, rng[3:0], '0, 1'b0);
        end
        release_req();
        wait_responses();
        check_count("o_drop_cnt", o_drop_cnt, exp_drops[15:0]);
        finish_test("rsp_backpressure", base);
    endtask

    initial begin
        i_wrstn     = 1'b0;
        i_rrstn     = 1'b0;
        i_req       = 1'b0;
        i_we        = 1'b0;
        i_addr      = '0;
        i_wdata     = '0;
        exp_tag     = '0;
        exp_drops   = 0;
        busy_drives = 0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        rng         = 32'hc49edfdf;
        for (int i = 0; i < REG_COUNT; i++) begin
            model[i] = '0;
        end

        repeat (8) @(posedge i_wclk);
        @(negedge i_wclk);
        i_wrstn = 1'b1;
        i_rrstn = 1'b1;

        test_reset_values();
        test_single_write_read();
        test_burst_overflow();
        test_random_mix();
        test_rsp_backpressure();

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_regbridge

`default_nettype wire
